// ==== verilog/lockin_macros.svh ====
`ifndef LOCKIN_MACROS_SVH
`define LOCKIN_MACROS_SVH

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------
`define LOCKIN_SAMPLE_W        14   // adc / dac sample
`define LOCKIN_BUS_W           32   // system bus word
`define LOCKIN_ADDR_W          20   // decoded address bits

// filter and gain constants
`define LOCKIN_HP_TAU_OFFSET   0
`define LOCKIN_LP_TAU_OFFSET   5    // low-pass runs slower for the same code
`define LOCKIN_FILT_FRAC_W     20   // accumulator fraction bits
`define LOCKIN_GAIN_SHIFT      10   // gain register is q.10

// ------------------------------------------------------------
// register map, byte addresses
// ------------------------------------------------------------
`define LOCKIN_REG_SCOPE_A_SEL 20'h00000
`define LOCKIN_REG_SCOPE_B_SEL 20'h00004
`define LOCKIN_REG_OUT1_SEL    20'h00010
`define LOCKIN_REG_OUT2_SEL    20'h00014
`define LOCKIN_REG_IN1         20'h00028   // read only from here to scope b
`define LOCKIN_REG_IN2         20'h0002C
`define LOCKIN_REG_OUT1        20'h00030
`define LOCKIN_REG_OUT2        20'h00034
`define LOCKIN_REG_SCOPE_A     20'h00048
`define LOCKIN_REG_SCOPE_B     20'h0004C
`define LOCKIN_REG_HP_TAU      20'h00050
`define LOCKIN_REG_LP_TAU      20'h00054
`define LOCKIN_REG_OFFSET      20'h00058
`define LOCKIN_REG_GAIN        20'h0005C
`define LOCKIN_REG_HP_DIS      20'h00060
`define LOCKIN_REG_LP_DIS      20'h00064
`define LOCKIN_REG_TAP_HP      20'h00070   // chain taps, read only
`define LOCKIN_REG_TAP_SIGN    20'h00074
`define LOCKIN_REG_TAP_RECT    20'h00078
`define LOCKIN_REG_TAP_LP      20'h0007C
`define LOCKIN_REG_TAP_SUM     20'h00080
`define LOCKIN_REG_TAP_GAIN    20'h00084

`endif

// ==== verilog/lockin_pkg.sv ====
`include "lockin_macros.svh"

package lockin_pkg;

    typedef logic signed [`LOCKIN_SAMPLE_W-1:0] sample_t;   // two's complement sample
    typedef logic        [`LOCKIN_BUS_W-1:0]    bus_word_t;
    typedef logic        [`LOCKIN_ADDR_W-1:0]   reg_addr_t;
    typedef logic        [3:0]                  tau_t;       // filter time constant code
    typedef logic        [3:0]                  out_sel_t;   // 16-way fast output mux
    typedef logic        [4:0]                  scope_sel_t; // 32-way scope mux

    // everything the cpu can write
    typedef struct packed {
        scope_sel_t scope_a_sel;
        scope_sel_t scope_b_sel;
        out_sel_t   out1_sel;
        out_sel_t   out2_sel;
        tau_t       hp_tau;
        tau_t       lp_tau;
        logic       hp_dis;   // high-pass bypass
        logic       lp_dis;   // low-pass bypass
        sample_t    offset;
        sample_t    gain;
    } ctrl_regs_t;

    // one sample per chain stage
    typedef struct packed {
        sample_t hp;
        sample_t sign;
        sample_t rect;
        sample_t lp;
        sample_t sum;
        sample_t gain;
    } chain_taps_t;

    localparam int SAMPLE_MAX = (1 << (`LOCKIN_SAMPLE_W - 1)) - 1;
    localparam int SAMPLE_MIN = -SAMPLE_MAX - 1;

    // clamp a wide signed value into sample range
    function automatic sample_t sat_sample(input logic signed [31:0] v);
        if (v > SAMPLE_MAX) return sample_t'(SAMPLE_MAX);
        if (v < SAMPLE_MIN) return sample_t'(SAMPLE_MIN);
        return sample_t'(v);
    endfunction

endpackage

// ==== verilog/iir_first_order.sv ====
`include "lockin_macros.svh"

module iir_first_order #(
    parameter bit HIGH_PASS  = 1'b0,
    parameter int TAU_OFFSET = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  lockin_pkg::tau_t     i_tau,
    input  logic                 i_bypass,
    input  lockin_pkg::sample_t  i_x,
    output lockin_pkg::sample_t  o_y
);

    localparam int W     = `LOCKIN_SAMPLE_W;
    localparam int F     = `LOCKIN_FILT_FRAC_W;
    localparam int ACC_W = W + F;
    localparam int DW    = ACC_W + 1;   // one guard bit for the difference
    localparam int HW    = W + 1;

    logic signed [ACC_W-1:0] acc;        // integer.fraction, tracks the input
    logic signed [ACC_W-1:0] x_ext;
    logic signed [DW-1:0]    diff;
    logic signed [DW-1:0]    acc_next;
    logic        [5:0]       shamt;
    lockin_pkg::sample_t     lp_int;
    logic signed [HW-1:0]    hp_full;
    lockin_pkg::sample_t     y_next;

    assign x_ext    = {i_x, {F{1'b0}}};                   // input aligned to the fraction
    assign shamt    = 6'(i_tau) + 6'(TAU_OFFSET);
    assign diff     = DW'(x_ext) - DW'(acc);
    assign acc_next = DW'(acc) + (diff >>> shamt);     // step toward the input
    assign lp_int   = acc_next[ACC_W-1:F];             // floor of the new state
    assign hp_full  = HW'(i_x) - HW'(lp_int);

    // high-pass is the residue after the low-pass estimate
    assign y_next = HIGH_PASS ? lockin_pkg::sat_sample(32'(hp_full)) : lp_int;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
            o_y <= '0;
        end else if (i_bypass) begin
            acc <= x_ext;   // preload so enabling starts without a jump
            o_y <= i_x;
        end else begin
            acc <= acc_next[ACC_W-1:0];   // stays between old state and input
            o_y <= y_next;
        end
    end

endmodule

// ==== verilog/sign_rectifier.sv ====
module sign_rectifier (
    input  logic                 clk,
    input  logic                 rst,
    input  lockin_pkg::sample_t  i_ref,    // high-pass output
    input  lockin_pkg::sample_t  i_sig,    // raw input 1
    output lockin_pkg::sample_t  o_sign,
    output lockin_pkg::sample_t  o_rect
);

    lockin_pkg::sample_t sig_d;     // input 1 aligned with the filtered reference
    lockin_pkg::sample_t neg_sig;
    logic                ref_pos;

    assign ref_pos = (i_ref >= 0);                            // zero counts as positive
    assign neg_sig = lockin_pkg::sat_sample(-32'(sig_d));    // -8192 -> 8191

    always_ff @(posedge clk) begin
        sig_d <= i_sig;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_sign <= '0;
            o_rect <= '0;
        end else begin
            o_sign <= ref_pos ? lockin_pkg::sample_t'(1) : lockin_pkg::sample_t'(-1);
            o_rect <= ref_pos ? sig_d : neg_sig;   // multiply by +-1
        end
    end

endmodule

// ==== verilog/offset_gain.sv ====
`include "lockin_macros.svh"

module offset_gain (
    input  logic                 clk,
    input  logic                 rst,
    input  lockin_pkg::sample_t  i_x,
    input  lockin_pkg::sample_t  i_offset,
    input  lockin_pkg::sample_t  i_gain,
    output lockin_pkg::sample_t  o_sum,
    output lockin_pkg::sample_t  o_gain
);

    localparam int PW = 2 * `LOCKIN_SAMPLE_W;   // full product width

    logic signed [PW-1:0] prod;
    logic signed [PW-1:0] prod_sh;

    // second stage works on the registered sum
    assign prod    = PW'(o_sum) * PW'(i_gain);
    assign prod_sh = prod >>> `LOCKIN_GAIN_SHIFT;   // arithmetic, keeps sign

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_sum  <= '0;
            o_gain <= '0;
        end else begin
            o_sum  <= lockin_pkg::sat_sample(32'(i_x) + 32'(i_offset));
            o_gain <= lockin_pkg::sat_sample(32'(prod_sh));
        end
    end

endmodule

// ==== verilog/signal_chain.sv ====
`include "lockin_macros.svh"

module signal_chain (
    input  logic                    clk,
    input  logic                    rst,
    input  lockin_pkg::sample_t     i_in1,
    input  lockin_pkg::ctrl_regs_t  i_ctrl,
    output lockin_pkg::chain_taps_t o_taps
);

    // one register per stage, in1 -> gain is 5 cycles with filters bypassed
    lockin_pkg::sample_t hp_y;     // in1 + 1
    lockin_pkg::sample_t sign_y;   // in1 + 2
    lockin_pkg::sample_t rect_y;   // in1 + 2
    lockin_pkg::sample_t lp_y;     // in1 + 3
    lockin_pkg::sample_t sum_y;    // in1 + 4
    lockin_pkg::sample_t gain_y;   // in1 + 5

    // ------------------------------------------------------------
    // reference path
    // ------------------------------------------------------------
    iir_first_order #(
        .HIGH_PASS  (1'b1),
        .TAU_OFFSET (`LOCKIN_HP_TAU_OFFSET)
    ) hp_filter_inst (
        .clk      (clk),
        .rst      (rst),
        .i_tau    (i_ctrl.hp_tau),
        .i_bypass (i_ctrl.hp_dis),
        .i_x      (i_in1),
        .o_y      (hp_y)
    );

    sign_rectifier sign_rectifier_inst (
        .clk    (clk),
        .rst    (rst),
        .i_ref  (hp_y),
        .i_sig  (i_in1),   // delayed inside to match hp_y
        .o_sign (sign_y),
        .o_rect (rect_y)
    );

    // ------------------------------------------------------------
    // demodulated path
    // ------------------------------------------------------------
    iir_first_order #(
        .HIGH_PASS  (1'b0),
        .TAU_OFFSET (`LOCKIN_LP_TAU_OFFSET)
    ) lp_filter_inst (
        .clk      (clk),
        .rst      (rst),
        .i_tau    (i_ctrl.lp_tau),
        .i_bypass (i_ctrl.lp_dis),
        .i_x      (rect_y),
        .o_y      (lp_y)
    );

    offset_gain offset_gain_inst (
        .clk      (clk),
        .rst      (rst),
        .i_x      (lp_y),
        .i_offset (i_ctrl.offset),
        .i_gain   (i_ctrl.gain),
        .o_sum    (sum_y),
        .o_gain   (gain_y)
    );

    assign o_taps = '{hp: hp_y, sign: sign_y, rect: rect_y,
                      lp: lp_y, sum: sum_y, gain: gain_y};

endmodule

// ==== verilog/reg_bank.sv ====
`include "lockin_macros.svh"

module reg_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  lockin_pkg::bus_word_t   i_sys_addr,
    input  lockin_pkg::bus_word_t   i_sys_wdata,
    input  logic                    i_sys_wen,
    input  logic                    i_sys_ren,
    input  lockin_pkg::sample_t     i_in1,
    input  lockin_pkg::sample_t     i_in2,
    input  lockin_pkg::sample_t     i_out1,
    input  lockin_pkg::sample_t     i_out2,
    input  lockin_pkg::sample_t     i_osc1,
    input  lockin_pkg::sample_t     i_osc2,
    input  lockin_pkg::chain_taps_t i_taps,
    output lockin_pkg::ctrl_regs_t  o_ctrl,
    output lockin_pkg::bus_word_t   o_sys_rdata,
    output logic                    o_sys_err,
    output logic                    o_sys_ack
);

    lockin_pkg::reg_addr_t  addr;
    lockin_pkg::ctrl_regs_t ctrl_q;
    lockin_pkg::bus_word_t  rd_next;

    assign addr   = i_sys_addr[`LOCKIN_ADDR_W-1:0];   // upper bits select the block elsewhere
    assign o_ctrl = ctrl_q;

    // ------------------------------------------------------------
    // write side
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_q             <= '0;
            ctrl_q.scope_a_sel <= 5'd1;   // in1
            ctrl_q.scope_b_sel <= 5'd2;   // in2
        end else if (i_sys_wen) begin
            case (addr)
                `LOCKIN_REG_SCOPE_A_SEL: ctrl_q.scope_a_sel <= i_sys_wdata[4:0];
                `LOCKIN_REG_SCOPE_B_SEL: ctrl_q.scope_b_sel <= i_sys_wdata[4:0];
                `LOCKIN_REG_OUT1_SEL:    ctrl_q.out1_sel    <= i_sys_wdata[3:0];
                `LOCKIN_REG_OUT2_SEL:    ctrl_q.out2_sel    <= i_sys_wdata[3:0];
                `LOCKIN_REG_HP_TAU:      ctrl_q.hp_tau      <= i_sys_wdata[3:0];
                `LOCKIN_REG_LP_TAU:      ctrl_q.lp_tau      <= i_sys_wdata[3:0];
                `LOCKIN_REG_OFFSET:      ctrl_q.offset <= i_sys_wdata[`LOCKIN_SAMPLE_W-1:0];
                `LOCKIN_REG_GAIN:        ctrl_q.gain   <= i_sys_wdata[`LOCKIN_SAMPLE_W-1:0];
                `LOCKIN_REG_HP_DIS:      ctrl_q.hp_dis      <= |i_sys_wdata;   // any bit set
                `LOCKIN_REG_LP_DIS:      ctrl_q.lp_dis      <= |i_sys_wdata;
                default: ;   // read-only or unmapped
            endcase
        end
    end

    // ------------------------------------------------------------
    // read side
    // ------------------------------------------------------------
    always_comb begin
        rd_next = '0;   // unmapped reads zero
        case (addr)
            `LOCKIN_REG_SCOPE_A_SEL: rd_next = 32'(ctrl_q.scope_a_sel);   // zero-extended
            `LOCKIN_REG_SCOPE_B_SEL: rd_next = 32'(ctrl_q.scope_b_sel);
            `LOCKIN_REG_OUT1_SEL:    rd_next = 32'(ctrl_q.out1_sel);
            `LOCKIN_REG_OUT2_SEL:    rd_next = 32'(ctrl_q.out2_sel);
            `LOCKIN_REG_IN1:         rd_next = 32'(i_in1);                // sign-extended
            `LOCKIN_REG_IN2:         rd_next = 32'(i_in2);
            `LOCKIN_REG_OUT1:        rd_next = 32'(i_out1);
            `LOCKIN_REG_OUT2:        rd_next = 32'(i_out2);
            `LOCKIN_REG_SCOPE_A:     rd_next = 32'(i_osc1);
            `LOCKIN_REG_SCOPE_B:     rd_next = 32'(i_osc2);
            `LOCKIN_REG_HP_TAU:      rd_next = 32'(ctrl_q.hp_tau);
            `LOCKIN_REG_LP_TAU:      rd_next = 32'(ctrl_q.lp_tau);
            `LOCKIN_REG_OFFSET:      rd_next = 32'(ctrl_q.offset);
            `LOCKIN_REG_GAIN:        rd_next = 32'(ctrl_q.gain);
            `LOCKIN_REG_HP_DIS:      rd_next = 32'(ctrl_q.hp_dis);
            `LOCKIN_REG_LP_DIS:      rd_next = 32'(ctrl_q.lp_dis);
            `LOCKIN_REG_TAP_HP:      rd_next = 32'(i_taps.hp);
            `LOCKIN_REG_TAP_SIGN:    rd_next = 32'(i_taps.sign);
            `LOCKIN_REG_TAP_RECT:    rd_next = 32'(i_taps.rect);
            `LOCKIN_REG_TAP_LP:      rd_next = 32'(i_taps.lp);
            `LOCKIN_REG_TAP_SUM:     rd_next = 32'(i_taps.sum);
            `LOCKIN_REG_TAP_GAIN:    rd_next = 32'(i_taps.gain);
            default: ;
        endcase
    end

    // data lines up with ack, one cycle after the strobe
    always_ff @(posedge clk) begin
        o_sys_rdata <= rd_next;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) o_sys_ack <= 1'b0;
        else     o_sys_ack <= i_sys_wen | i_sys_ren;   // every access answered
    end

    assign o_sys_err = 1'b0;   // no error responses on this block

endmodule

// ==== verilog/output_router.sv ====
module output_router (
    input  logic                    clk,
    input  logic                    rst,
    input  lockin_pkg::sample_t     i_in1,
    input  lockin_pkg::sample_t     i_in2,
    input  lockin_pkg::chain_taps_t i_taps,
    input  lockin_pkg::ctrl_regs_t  i_ctrl,
    output lockin_pkg::sample_t     o_out1,
    output lockin_pkg::sample_t     o_out2,
    output lockin_pkg::sample_t     o_osc1,
    output lockin_pkg::sample_t     o_osc2
);

    // fast dac mux, codes 4..15 unused
    function automatic lockin_pkg::sample_t fast_pick(input lockin_pkg::out_sel_t sel,
                                                      input lockin_pkg::sample_t  in1,
                                                      input lockin_pkg::sample_t  in2,
                                                      input lockin_pkg::sample_t  gain);
        case (sel)
            4'd1:    return in1;
            4'd2:    return in2;
            4'd3:    return gain;   // demodulator result
            default: return '0;
        endcase
    endfunction

    // scope mux, every chain tap visible, codes 9..31 unused
    function automatic lockin_pkg::sample_t scope_pick(input lockin_pkg::scope_sel_t  sel,
                                                       input lockin_pkg::sample_t     in1,
                                                       input lockin_pkg::sample_t     in2,
                                                       input lockin_pkg::chain_taps_t taps);
        case (sel)
            5'd1:    return in1;
            5'd2:    return in2;
            5'd3:    return taps.hp;
            5'd4:    return taps.sign;
            5'd5:    return taps.rect;
            5'd6:    return taps.lp;
            5'd7:    return taps.sum;
            5'd8:    return taps.gain;
            default: return '0;
        endcase
    endfunction

    assign o_out1 = fast_pick(i_ctrl.out1_sel, i_in1, i_in2, i_taps.gain);   // no register
    assign o_out2 = fast_pick(i_ctrl.out2_sel, i_in1, i_in2, i_taps.gain);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_osc1 <= '0;
            o_osc2 <= '0;
        end else begin
            o_osc1 <= scope_pick(i_ctrl.scope_a_sel, i_in1, i_in2, i_taps);   // 1 cycle lag
            o_osc2 <= scope_pick(i_ctrl.scope_b_sel, i_in1, i_in2, i_taps);
        end
    end

endmodule

// ==== verilog/lockin_top.sv ====
module lockin_top (
    input  logic                  clk,
    input  logic                  rst,
    input  lockin_pkg::sample_t   i_in1,
    input  lockin_pkg::sample_t   i_in2,
    input  lockin_pkg::bus_word_t i_sys_addr,
    input  lockin_pkg::bus_word_t i_sys_wdata,
    input  logic                  i_sys_wen,
    input  logic                  i_sys_ren,
    output lockin_pkg::sample_t   o_out1,
    output lockin_pkg::sample_t   o_out2,
    output lockin_pkg::sample_t   o_osc1,
    output lockin_pkg::sample_t   o_osc2,
    output lockin_pkg::bus_word_t o_sys_rdata,
    output logic                  o_sys_err,
    output logic                  o_sys_ack
);

    lockin_pkg::ctrl_regs_t  ctrl;   // cpu settings
    lockin_pkg::chain_taps_t taps;   // every stage of the demodulator

    reg_bank reg_bank_inst (
        .clk         (clk),
        .rst         (rst),
        .i_sys_addr  (i_sys_addr),
        .i_sys_wdata (i_sys_wdata),
        .i_sys_wen   (i_sys_wen),
        .i_sys_ren   (i_sys_ren),
        .i_in1       (i_in1),
        .i_in2       (i_in2),
        .i_out1      (o_out1),   // readback of what leaves the chip
        .i_out2      (o_out2),
        .i_osc1      (o_osc1),
        .i_osc2      (o_osc2),
        .i_taps      (taps),
        .o_ctrl      (ctrl),
        .o_sys_rdata (o_sys_rdata),
        .o_sys_err   (o_sys_err),
        .o_sys_ack   (o_sys_ack)
    );

    signal_chain signal_chain_inst (
        .clk    (clk),
        .rst    (rst),
        .i_in1  (i_in1),
        .i_ctrl (ctrl),
        .o_taps (taps)
    );

    output_router output_router_inst (
        .clk    (clk),
        .rst    (rst),
        .i_in1  (i_in1),
        .i_in2  (i_in2),
        .i_taps (taps),
        .i_ctrl (ctrl),
        .o_out1 (o_out1),
        .o_out2 (o_out2),
        .o_osc1 (o_osc1),
        .o_osc2 (o_osc2)
    );

endmodule

// ==== bench/lockin_sva.sv ====
module lockin_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   i_sys_wen,
    input logic                   i_sys_ren,
    input logic                   i_sys_ack,
    input logic                   i_sys_err,
    input lockin_pkg::out_sel_t   i_out1_sel,
    input lockin_pkg::sample_t    i_out1
);

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------
    // bus handshake
    // ------------------------------------------------------------
    ack_after_strobe: assert property (@(posedge clk) disable iff (rst)
        (i_sys_wen || i_sys_ren) |=> i_sys_ack)
        else $error("bus strobe not acknowledged on the next cycle");

    // no stray ack without a strobe
    ack_only_after_strobe: assert property (@(posedge clk) disable iff (rst)
        !(i_sys_wen || i_sys_ren) |=> !i_sys_ack)
        else $error("bus acknowledge without a strobe");

    err_never: assert property (@(posedge clk) disable iff (rst) !i_sys_err)
        else $error("bus error response raised");

    // fast output muted by select 0
    out1_muted: assert property (@(posedge clk) disable iff (rst)
        (i_out1_sel == '0) |-> (i_out1 == '0))
        else $error("out1 not zero with select 0");

endmodule

bind lockin_top lockin_sva lockin_sva_inst (
    .clk        (clk),
    .rst        (rst),
    .i_sys_wen  (i_sys_wen),
    .i_sys_ren  (i_sys_ren),
    .i_sys_ack  (o_sys_ack),
    .i_sys_err  (o_sys_err),
    .i_out1_sel (ctrl.out1_sel),   // register bank output inside the top
    .i_out1     (o_out1)
);

// ==== bench/lockin_tb.sv ====
`include "lockin_macros.svh"

module lockin_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_LIMIT = 20000;   // the tests take about 3500 cycles

    logic                  clk;
    logic                  rst;
    lockin_pkg::sample_t   in1;
    lockin_pkg::sample_t   in2;
    lockin_pkg::bus_word_t sys_addr;
    lockin_pkg::bus_word_t sys_wdata;
    logic                  sys_wen;
    logic                  sys_ren;
    lockin_pkg::sample_t   out1;
    lockin_pkg::sample_t   out2;
    lockin_pkg::sample_t   osc1;
    lockin_pkg::sample_t   osc2;
    lockin_pkg::bus_word_t sys_rdata;
    logic                  sys_err;
    logic                  sys_ack;
    int                    seed = 72;
    int                    cycles = 0;

    lockin_top lockin_top_inst (
        .clk (clk), .rst (rst), .i_in1 (in1), .i_in2 (in2),
        .i_sys_addr (sys_addr), .i_sys_wdata (sys_wdata),
        .i_sys_wen (sys_wen), .i_sys_ren (sys_ren),
        .o_out1 (out1), .o_out2 (out2), .o_osc1 (osc1), .o_osc2 (osc2),
        .o_sys_rdata (sys_rdata), .o_sys_err (sys_err), .o_sys_ack (sys_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reporting and the reference model
    // ------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            abort_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
    end

    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp) else
            abort_run($sformatf("error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
    endtask

    task automatic check_near(input string name, input int got, input int exp, input int tol);
        assert (got >= exp - tol && got <= exp + tol) else
            abort_run($sformatf("error at %0t: %s = %0d, expected %0d +- %0d",
                                $time, name, got, exp, tol));
    endtask

    function automatic int clamp(input int v);
        if (v > 8191)  return 8191;    // 14-bit signed range
        if (v < -8192) return -8192;
        return v;
    endfunction

    function automatic lockin_pkg::sample_t to_s(input int v);
        return lockin_pkg::sample_t'(v);
    endfunction

    function automatic int rand_sample();
        int r;
        r = $random(seed);
        return int'(to_s(r));   // low 14 bits as a signed sample
    endfunction

    // both filters bypassed, steady input
    function automatic lockin_pkg::chain_taps_t bypass_model(input int x, input int off,
                                                             input int g);
        int s;
        int r;
        int sm;
        lockin_pkg::chain_taps_t t;
        s      = (x >= 0) ? 1 : -1;   // hp passes in1 straight through
        r      = clamp(x * s);
        sm     = clamp(r + off);
        t.hp   = to_s(x);
        t.sign = to_s(s);
        t.rect = to_s(r);
        t.lp   = to_s(r);
        t.sum  = to_s(sm);
        t.gain = to_s(clamp((sm * g) >>> `LOCKIN_GAIN_SHIFT));
        return t;
    endfunction

    function automatic int fast_expect(input int sel, input int a, input int b, input int g);
        case (sel)
            1:       return a;
            2:       return b;
            3:       return g;
            default: return 0;
        endcase
    endfunction

    function automatic int scope_expect(input int sel, input int a, input int b,
                                        input lockin_pkg::chain_taps_t t);
        case (sel)
            1:       return a;
            2:       return b;
            3:       return int'(t.hp);
            4:       return int'(t.sign);
            5:       return int'(t.rect);
            6:       return int'(t.lp);
            7:       return int'(t.sum);
            8:       return int'(t.gain);
            default: return 0;
        endcase
    endfunction

    // ------------------------------------------------------------
    // bus access
    // ------------------------------------------------------------
    task automatic bus_write(input int addr, input int data);
        @(posedge clk);
        sys_addr  <= addr;
        sys_wdata <= data;
        sys_wen   <= 1'b1;
        @(posedge clk);
        sys_wen <= 1'b0;
        @(negedge clk);   // ack settled mid-cycle
        assert (sys_ack && !sys_err) else
            abort_run($sformatf("write to 0x%02h got no clean acknowledge", addr));
    endtask

    task automatic bus_read(input int addr, output int data);
        @(posedge clk);
        sys_addr <= addr;
        sys_ren  <= 1'b1;
        @(posedge clk);
        sys_ren <= 1'b0;
        @(negedge clk);
        assert (sys_ack && !sys_err) else
            abort_run($sformatf("read of 0x%02h got no clean acknowledge", addr));
        data = int'(sys_rdata);
    endtask

    task automatic check_reg(input int addr, input int exp);
        int rd;
        bus_read(addr, rd);
        check_eq($sformatf("o_sys_rdata at 0x%02h", addr), rd, exp);
    endtask

    task automatic apply_chain(input int x, input int off, input int g);
        bus_write(`LOCKIN_REG_OFFSET, off);
        bus_write(`LOCKIN_REG_GAIN, g);
        @(posedge clk);
        in1 <= to_s(x);
        repeat (8) @(posedge clk);   // chain is 5 deep
        @(negedge clk);
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic run_register_access();
        int zero_regs[8] = '{`LOCKIN_REG_OUT1_SEL, `LOCKIN_REG_OUT2_SEL, `LOCKIN_REG_HP_TAU,
                             `LOCKIN_REG_LP_TAU, `LOCKIN_REG_OFFSET, `LOCKIN_REG_GAIN,
                             `LOCKIN_REG_HP_DIS, `LOCKIN_REG_LP_DIS};
        check_reg(`LOCKIN_REG_SCOPE_A_SEL, 1);   // reset selects in1, in2
        check_reg(`LOCKIN_REG_SCOPE_B_SEL, 2);
        foreach (zero_regs[i]) check_reg(zero_regs[i], 0);
        bus_write(`LOCKIN_REG_SCOPE_A_SEL, 17);
        bus_write(`LOCKIN_REG_SCOPE_B_SEL, 9);
        bus_write(`LOCKIN_REG_OUT1_SEL, 10);
        bus_write(`LOCKIN_REG_OUT2_SEL, 3);
        bus_write(`LOCKIN_REG_HP_TAU, 7);
        bus_write(`LOCKIN_REG_LP_TAU, 12);
        bus_write(`LOCKIN_REG_OFFSET, -1234);
        bus_write(`LOCKIN_REG_GAIN, 'h2345);     // bit 13 set, reads negative
        bus_write(`LOCKIN_REG_HP_DIS, 'h10000);  // any set bit enables
        bus_write(`LOCKIN_REG_LP_DIS, 'h80000000);
        check_reg(`LOCKIN_REG_SCOPE_A_SEL, 17);
        check_reg(`LOCKIN_REG_SCOPE_B_SEL, 9);
        check_reg(`LOCKIN_REG_OUT1_SEL, 10);
        check_reg(`LOCKIN_REG_OUT2_SEL, 3);
        check_reg(`LOCKIN_REG_HP_TAU, 7);
        check_reg(`LOCKIN_REG_LP_TAU, 12);
        check_reg(`LOCKIN_REG_OFFSET, -1234);
        check_reg(`LOCKIN_REG_GAIN, 'h2345 - 'h4000);
        check_reg(`LOCKIN_REG_HP_DIS, 1);
        check_reg(`LOCKIN_REG_LP_DIS, 1);
        bus_write(`LOCKIN_REG_HP_DIS, 0);
        check_reg(`LOCKIN_REG_HP_DIS, 0);
        check_reg('h90, 0);   // unmapped
        check_reg('h20, 0);   // dropped block
    endtask

    task automatic run_fast_routing();
        int sels[4] = '{0, 1, 2, 9};
        int a;
        int b;
        int s1;
        int s2;
        foreach (sels[i]) begin
            s1 = sels[i];
            s2 = sels[3 - i];
            bus_write(`LOCKIN_REG_OUT1_SEL, s1);
            bus_write(`LOCKIN_REG_OUT2_SEL, s2);
            repeat (4) begin
                a = rand_sample();
                b = rand_sample();
                @(posedge clk);
                in1 <= to_s(a);
                in2 <= to_s(b);
                @(negedge clk);   // same cycle, no register
                check_eq("o_out1", int'(out1), fast_expect(s1, a, b, 0));
                check_eq("o_out2", int'(out2), fast_expect(s2, a, b, 0));
            end
            check_reg(`LOCKIN_REG_IN1, a);
            check_reg(`LOCKIN_REG_IN2, b);
            check_reg(`LOCKIN_REG_OUT1, fast_expect(s1, a, b, 0));
            check_reg(`LOCKIN_REG_OUT2, fast_expect(s2, a, b, 0));
        end
    endtask

    task automatic run_bypassed_chain(input int rounds);
        int x;
        int off;
        int g;
        lockin_pkg::chain_taps_t m;
        bus_write(`LOCKIN_REG_HP_DIS, 1);
        bus_write(`LOCKIN_REG_LP_DIS, 1);
        bus_write(`LOCKIN_REG_OUT1_SEL, 3);   // gain tap on out1
        repeat (rounds) begin
            x   = rand_sample();
            off = rand_sample() / 4;
            g   = rand_sample();
            m   = bypass_model(x, off, g);
            apply_chain(x, off, g);
            check_eq("o_out1", int'(out1), int'(m.gain));
            check_reg(`LOCKIN_REG_TAP_HP, int'(m.hp));
            check_reg(`LOCKIN_REG_TAP_SIGN, int'(m.sign));
            check_reg(`LOCKIN_REG_TAP_RECT, int'(m.rect));
            check_reg(`LOCKIN_REG_TAP_LP, int'(m.lp));
            check_reg(`LOCKIN_REG_TAP_SUM, int'(m.sum));
        end
    endtask

    task automatic run_saturation();
        apply_chain(3000, 8000, 1024);   // sum over the top
        check_reg(`LOCKIN_REG_TAP_SUM, 8191);
        apply_chain(3000, 100, 8191);    // product over the top
        check_reg(`LOCKIN_REG_TAP_SUM, 3100);
        check_reg(`LOCKIN_REG_TAP_GAIN, 8191);
        apply_chain(-3000, -8000, 8191);
        check_reg(`LOCKIN_REG_TAP_SUM, -5000);
        check_reg(`LOCKIN_REG_TAP_GAIN, -8192);
        apply_chain(0, -8192, 1024);
        check_reg(`LOCKIN_REG_TAP_SUM, -8192);
        apply_chain(-8192, 0, 1024);     // negating the minimum clips
        check_reg(`LOCKIN_REG_TAP_RECT, 8191);
    endtask

    task automatic run_filters();
        int rd;
        bus_write(`LOCKIN_REG_HP_TAU, 2);
        bus_write(`LOCKIN_REG_LP_TAU, 0);
        apply_chain(0, 0, 1024);          // filters preload zero
        bus_write(`LOCKIN_REG_HP_DIS, 0);
        bus_write(`LOCKIN_REG_LP_DIS, 0);
        repeat (10) @(posedge clk);
        in1 <= to_s(3000);                // step
        repeat (800) @(posedge clk);
        bus_read(`LOCKIN_REG_TAP_HP, rd);
        check_near("hp tap", rd, 0, 2);
        bus_read(`LOCKIN_REG_TAP_LP, rd);
        check_near("lp tap", rd, 3000, 2);
        bus_read(`LOCKIN_REG_TAP_RECT, rd);
        check_near("rect tap", rd, 3000, 2);
    endtask

    task automatic run_scope_channels();
        int codes[10] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 20};
        int a;
        int b;
        lockin_pkg::chain_taps_t m;
        bus_write(`LOCKIN_REG_HP_DIS, 1);
        bus_write(`LOCKIN_REG_LP_DIS, 1);
        @(posedge clk);
        in2 <= to_s(-777);
        apply_chain(-1234, 100, 2048);   // negative in1 keeps in1 and hp apart from rect
        m = bypass_model(-1234, 100, 2048);
        foreach (codes[i]) begin
            a = codes[i];
            b = codes[9 - i];
            bus_write(`LOCKIN_REG_SCOPE_A_SEL, a);
            bus_write(`LOCKIN_REG_SCOPE_B_SEL, b);
            repeat (2) @(posedge clk);   // registered mux
            @(negedge clk);
            check_eq("o_osc1", int'(osc1), scope_expect(a, -1234, -777, m));
            check_eq("o_osc2", int'(osc2), scope_expect(b, -1234, -777, m));
            check_reg(`LOCKIN_REG_SCOPE_A, scope_expect(a, -1234, -777, m));
            check_reg(`LOCKIN_REG_SCOPE_B, scope_expect(b, -1234, -777, m));
        end
    endtask

    // ------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------
    initial begin
        rst       = 1'b1;
        in1       = '0;
        in2       = '0;
        sys_addr  = '0;
        sys_wdata = '0;
        sys_wen   = 1'b0;
        sys_ren   = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        run_register_access();
        run_fast_routing();
        run_bypassed_chain(60);
        run_saturation();
        run_filters();
        run_scope_channels();
        repeat (4) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/lockin_pkg.sv
verilog/iir_first_order.sv
verilog/sign_rectifier.sv
verilog/offset_gain.sv
verilog/signal_chain.sv
verilog/reg_bank.sv
verilog/output_router.sv
verilog/lockin_top.sv
bench/lockin_sva.sv
bench/lockin_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= lockin_tb
RTL_TOP   ?= lockin_top
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)
